//--- filelist.f
hw/ipv4_rx_pkg.sv
hw/ipv4_hdr_parse.sv
hw/ipv4_cks_acc.sv
hw/ipv4_rx_gate.sv
hw/ipv4_rx_top.sv
sim/tb_clkgen.sv
sim/ipv4_rx_tb.sv

//--- Makefile
# Verilator build and run for the IPv4 receive path
VERILATOR ?= verilator
TOP       ?= ipv4_rx_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the simulator
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/ipv4_rx_testdata.txt
// columns: dev_ip, frame byte count, frame bytes, then the outcome code
// outcome 0 is followed by src_ip id proto pld_len and the payload, 1..5 is the drop reason
// unicast, 20-byte header, 4 payload bytes
c0a80001 18 45 00 00 18 12 34 00 00 40 11 e7 4d c0 a8 00 02 c0 a8 00 01 de ad be ef
0 c0a80002 1234 11 4 de ad be ef
// ethernet padding after total_len is trimmed
c0a80001 1a 45 00 00 16 12 35 00 00 40 11 e7 4e c0 a8 00 02 c0 a8 00 01 01 02 00 00 00 00
0 c0a80002 1235 11 2 01 02
// ihl 6, one word of options skipped
c0a80001 1a 46 00 00 1a 12 36 00 00 40 11 e4 47 c0 a8 00 02 c0 a8 00 01 01 01 01 01 aa 55
0 c0a80002 1236 11 2 aa 55
// limited broadcast
c0a80001 17 45 00 00 17 12 37 00 00 40 11 a7 f5 c0 a8 00 02 ff ff ff ff 11 22 33
0 c0a80002 1237 11 3 11 22 33
// another unicast host, not_for_us
c0a80001 16 45 00 00 16 12 38 00 00 40 11 e7 43 c0 a8 00 02 c0 a8 00 09 01 02
4
// bad checksum and wrong address, checksum ranks first
c0a80001 18 45 00 00 18 12 34 00 00 40 11 e7 4c c0 a8 00 02 c0 a8 00 09 de ad be ef
3
// version 6 with bad checksum and wrong address
c0a80001 18 65 00 00 18 12 34 00 00 40 11 00 00 c0 a8 00 02 c0 a8 00 09 de ad be ef
1
// ihl 4 with bad checksum
c0a80001 18 44 00 00 18 12 34 00 00 40 11 00 00 c0 a8 00 02 c0 a8 00 01 de ad be ef
2
// frame ends inside the header
c0a80001 0a 45 00 00 18 12 34 00 00 40 11
5
// next frame still accepted, device address changed to match
c0a80009 16 45 00 00 16 12 38 00 00 40 11 e7 43 c0 a8 00 02 c0 a8 00 09 01 02
0 c0a80002 1238 11 2 01 02
// end of records
0 0

//--- sim/ipv4_rx_tb.sv
`timescale 1ns/1ps

module ipv4_rx_tb;

  localparam int          timeout_margin = 100;
  localparam logic [31:0] rng_seed       = 32'd95;
  localparam string       data_file      = "sim/ipv4_rx_testdata.txt";

  logic        clk;
  logic        fsm_rst;
  logic        in_val, in_sof, in_eof;
  logic [7:0]  in_dat;
  logic [31:0] dev_ip;
  logic        out_val, out_sof, out_eof, meta_val, drop;
  logic [7:0]  out_dat;
  logic [31:0] src_ip_out;
  logic [15:0] id_out;
  logic [7:0]  proto_out;
  logic [15:0] pld_len;
  ipv4_rx_pkg::drop_reason_t drop_reason;

  // file image and what one frame produced
  logic [31:0] mem [0:1023];
  logic [31:0] rng;
  logic [7:0]  got_q [$];
  logic [31:0] m_src;
  logic [15:0] m_id, m_len;
  logic [7:0]  m_proto;
  logic [2:0]  got_reason;
  int          meta_n, drop_n, sof_n, eof_n, eof_at;
  int          errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          cycles = 0;
  int          limit = 1000000;

  tb_clkgen u_clk (.clk(clk));

  ipv4_rx_top uut (
    .clk(clk), .fsm_rst(fsm_rst),
    .in_val(in_val), .in_sof(in_sof), .in_eof(in_eof), .in_dat(in_dat), .dev_ip(dev_ip),
    .out_val(out_val), .out_sof(out_sof), .out_eof(out_eof), .out_dat(out_dat),
    .meta_val(meta_val), .src_ip_out(src_ip_out), .id_out(id_out),
    .proto_out(proto_out), .pld_len(pld_len), .drop(drop), .drop_reason(drop_reason)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // outputs change on the rising edge, so they are steady here
  task automatic sample_outputs();
    if (meta_val || (out_val && out_sof)) begin
      check_field("meta_val", {31'b0, out_val && out_sof}, {31'b0, meta_val});
    end
    if (out_val) begin
      if (out_sof) begin
        sof_n++;
        check_field("out_sof byte index", 0, got_q.size());
      end
      if (out_eof) begin
        eof_n++;
        eof_at = got_q.size();
      end
      got_q.push_back(out_dat);
    end
    if (meta_val) begin
      meta_n++;
      m_src   = src_ip_out;
      m_id    = id_out;
      m_proto = proto_out;
      m_len   = pld_len;
    end
    if (drop) begin
      drop_n++;
      got_reason = drop_reason;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the DUT never finished the current frame", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int p, n, t, i, j, err0, total;
    logic [31:0] kind;
    logic        idle_prev, done;
    fsm_rst = 1'b1;
    in_val  = 1'b0;
    in_sof  = 1'b0;
    in_eof  = 1'b0;
    in_dat  = 8'h00;
    dev_ip  = 32'h0;
    rng     = rng_seed;
    $readmemh(data_file, mem);

    // size the run from the frame lengths, at most two cycles per byte
    p = 0;
    total = 0;
    while (p < 1000 && mem[p + 1] != 0) begin
      total += mem[p + 1];
      p += 2 + mem[p + 1];
      p += (mem[p] == 0) ? 5 + mem[p + 4] : 1;
    end
    limit = total * 3 + timeout_margin;
    if (total == 0) begin
      $display("no frames could be read from %s", data_file);
      errors++;
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_field("outputs in reset", 0, {27'b0, out_val, out_sof, out_eof, meta_val, drop});
    fsm_rst = 1'b0;

    p = 0;
    t = 0;
    while (p < 1000 && mem[p + 1] != 0) begin
      t++;
      err0   = errors;
      dev_ip = mem[p];
      n      = mem[p + 1];
      kind   = mem[p + 2 + n];
      got_q.delete();
      meta_n = 0;
      drop_n = 0;
      sof_n  = 0;
      eof_n  = 0;
      eof_at = -1;
      i = 0;
      idle_prev = 1'b0;
      done = 1'b0;
      // keep going until the frame is sent, the bus is idle and the DUT has answered
      while (i < n || in_val || !done) begin
        @(negedge clk);
        sample_outputs();
        done = (kind == 0) ? (eof_n != 0) : (drop_n != 0);
        rng = xorshift(rng);
        if (i < n && (idle_prev || rng[1:0] != 2'd0)) begin
          in_val = 1'b1;
          in_sof = (i == 0);
          in_eof = (i == n - 1);
          in_dat = mem[p + 2 + i][7:0];
          i++;
          idle_prev = 1'b0;
        end else begin
          in_val = 1'b0;
          in_sof = 1'b0;
          in_eof = 1'b0;
          idle_prev = 1'b1;
        end
      end

      if (kind == 0) begin
        j = p + 3 + n;
        check_field("meta_val count", 1, meta_n);
        check_field("src_ip_out", mem[j], m_src);
        check_field("id_out", mem[j + 1], {16'b0, m_id});
        check_field("proto_out", mem[j + 2], {24'b0, m_proto});
        check_field("pld_len", mem[j + 3], {16'b0, m_len});
        check_field("payload byte count", mem[j + 3], got_q.size());
        check_field("out_sof count", 1, sof_n);
        check_field("out_eof count", 1, eof_n);
        check_field("out_eof byte index", mem[j + 3] - 1, eof_at);
        check_field("drop count", 0, drop_n);
        for (i = 0; i < got_q.size() && i < mem[j + 3]; i++) begin
          check_field("out_dat", mem[j + 4 + i], {24'b0, got_q[i]});
        end
        p = j + 4 + mem[j + 3];
      end else begin
        check_field("drop count", 1, drop_n);
        check_field("drop_reason", kind, {29'b0, got_reason});
        check_field("payload byte count", 0, got_q.size());
        check_field("meta_val count", 0, meta_n);
        p = p + 3 + n;
      end

      if (errors == err0) begin
        n_pass++;
        $display("test %0d (%s) ok", t, (kind == 0) ? "accept" : "drop");
      end else begin
        n_fail++;
        $display("test %0d (%s) has mismatches", t, (kind == 0) ? "accept" : "drop");
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", t, n_pass, n_fail, errors);
    if (errors == 0 && t != 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

//--- hw/ipv4_rx_top.sv
`timescale 1ns/1ps

module ipv4_rx_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      in_val,
  input  logic                      in_sof,
  input  logic                      in_eof,
  input  logic [7:0]                in_dat,
  input  logic [31:0]               dev_ip,
  output logic                      out_val,
  output logic                      out_sof,
  output logic                      out_eof,
  output logic [7:0]                out_dat,
  output logic                      meta_val,
  output logic [31:0]               src_ip_out,
  output logic [15:0]               id_out,
  output logic [7:0]                proto_out,
  output logic [15:0]               pld_len,
  output logic                      drop,
  output ipv4_rx_pkg::drop_reason_t drop_reason
);

  logic        hdr_done;
  logic        frame_short;
  logic [3:0]  version;
  logic [3:0]  ihl;
  logic [15:0] total_len;
  logic [15:0] id;
  logic [7:0]  proto;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] cks_sum;

  // parser and checksum both watch the raw stream
  ipv4_hdr_parse u_parse (
    .clk(clk), .fsm_rst(fsm_rst),
    .in_val(in_val), .in_sof(in_sof), .in_eof(in_eof), .in_dat(in_dat),
    .hdr_done(hdr_done), .frame_short(frame_short),
    .version(version), .ihl(ihl), .total_len(total_len), .id(id),
    .proto(proto), .src_ip(src_ip), .dst_ip(dst_ip)
  );

  ipv4_cks_acc u_cks (
    .clk(clk), .fsm_rst(fsm_rst),
    .in_val(in_val), .in_sof(in_sof), .in_dat(in_dat),
    .cks_sum(cks_sum)
  );

  ipv4_rx_gate u_gate (
    .clk(clk), .fsm_rst(fsm_rst),
    .in_val(in_val), .in_eof(in_eof), .in_dat(in_dat), .dev_ip(dev_ip),
    .hdr_done(hdr_done), .frame_short(frame_short),
    .version(version), .ihl(ihl), .total_len(total_len), .id(id),
    .proto(proto), .src_ip(src_ip), .dst_ip(dst_ip), .cks_sum(cks_sum),
    .out_val(out_val), .out_sof(out_sof), .out_eof(out_eof), .out_dat(out_dat),
    .meta_val(meta_val), .src_ip_out(src_ip_out), .id_out(id_out),
    .proto_out(proto_out), .pld_len(pld_len),
    .drop(drop), .drop_reason(drop_reason)
  );

endmodule

//--- hw/ipv4_rx_gate.sv
`timescale 1ns/1ps

module ipv4_rx_gate (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      in_val,
  input  logic                      in_eof,
  input  logic [7:0]                in_dat,
  input  logic [31:0]               dev_ip,
  input  logic                      hdr_done,
  input  logic                      frame_short,
  input  logic [3:0]                version,
  input  logic [3:0]                ihl,
  input  logic [15:0]               total_len,
  input  logic [15:0]               id,
  input  logic [7:0]                proto,
  input  logic [31:0]               src_ip,
  input  logic [31:0]               dst_ip,
  input  logic [15:0]               cks_sum,
  output logic                      out_val,
  output logic                      out_sof,
  output logic                      out_eof,
  output logic [7:0]                out_dat,
  output logic                      meta_val,
  output logic [31:0]               src_ip_out,
  output logic [15:0]               id_out,
  output logic [7:0]                proto_out,
  output logic [15:0]               pld_len,
  output logic                      drop,
  output ipv4_rx_pkg::drop_reason_t drop_reason
);

  ipv4_rx_pkg::drop_reason_t reason;
  ipv4_rx_pkg::drop_reason_t reason_q;
  logic        drop_q;
  logic        fwd;
  logic        eof_d;
  logic [15:0] cnt;
  logic [15:0] hdr_bytes;
  logic [15:0] pld_calc;
  logic        go;
  logic [15:0] len;
  logic [15:0] cnt_cur;
  logic        first;
  logic        last;

  assign hdr_bytes = {10'b0, ihl, 2'b00};
  // a total length shorter than the header leaves nothing to forward
  assign pld_calc  = (total_len > hdr_bytes) ? (total_len - hdr_bytes) : 16'd0;

  // first failing check wins
  always_comb begin
    if (version != ipv4_rx_pkg::ipv4_version) begin
      reason = ipv4_rx_pkg::drop_bad_version;
    end else if (ihl < 4'(ipv4_rx_pkg::ipv4_min_hdr_len / 4)) begin
      reason = ipv4_rx_pkg::drop_bad_ihl;
    end else if (cks_sum != ipv4_rx_pkg::cks_good) begin
      reason = ipv4_rx_pkg::drop_bad_cks;
    end else if (dst_ip != dev_ip && dst_ip != ipv4_rx_pkg::ipv4_broadcast) begin
      reason = ipv4_rx_pkg::drop_not_for_us;
    end else begin
      reason = ipv4_rx_pkg::drop_none;
    end
  end

  // the first payload byte may already be on the bus in the hdr_done cycle
  assign go      = hdr_done ? (reason == ipv4_rx_pkg::drop_none && pld_calc != 16'd0 && !eof_d)
                            : fwd;
  assign len     = hdr_done ? pld_calc : pld_len;
  assign cnt_cur = hdr_done ? 16'd0 : cnt;
  assign first   = (cnt_cur == 16'd0);
  assign last    = (cnt_cur + 16'd1 == len) || in_eof;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      fwd      <= 1'b0;
      cnt      <= '0;
      eof_d    <= 1'b0;
      out_val  <= 1'b0;
      out_sof  <= 1'b0;
      out_eof  <= 1'b0;
      meta_val <= 1'b0;
      drop_q   <= 1'b0;
      reason_q <= ipv4_rx_pkg::drop_none;
    end else begin
      // frame closed on its last header byte
      eof_d  <= in_val && in_eof;
      drop_q <= hdr_done && (reason != ipv4_rx_pkg::drop_none);
      if (hdr_done) begin
        reason_q <= reason;
      end
      if (in_val && go) begin
        out_val  <= 1'b1;
        out_sof  <= first;
        out_eof  <= last;
        meta_val <= first;
        cnt      <= cnt_cur + 16'd1;
        fwd      <= !last;
      end else begin
        out_val  <= 1'b0;
        out_sof  <= 1'b0;
        out_eof  <= 1'b0;
        meta_val <= 1'b0;
        // an idle hdr_done cycle still starts the payload count from zero
        cnt      <= cnt_cur;
        fwd      <= go;
      end
    end
  end

  // payload and metadata registers
  always_ff @(posedge clk) begin
    out_dat <= in_dat;
    if (hdr_done && reason == ipv4_rx_pkg::drop_none) begin
      src_ip_out <= src_ip;
      id_out     <= id;
      proto_out  <= proto;
      pld_len    <= pld_calc;
    end
  end

  // short frames come straight from the parser, already one cycle after in_eof
  assign drop        = drop_q | frame_short;
  assign drop_reason = drop_q      ? reason_q :
                       frame_short ? ipv4_rx_pkg::drop_short_frame :
                                     ipv4_rx_pkg::drop_none;

  a_sof_has_val: assert property (
    @(posedge clk) disable iff (fsm_rst)
    out_sof |-> out_val
  );

  a_drop_no_data: assert property (
    @(posedge clk) disable iff (fsm_rst)
    !(drop && out_val)
  );

endmodule

//--- hw/ipv4_cks_acc.sv
`timescale 1ns/1ps

module ipv4_cks_acc (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        in_val,
  input  logic        in_sof,
  input  logic [7:0]  in_dat,
  output logic [15:0] cks_sum
);

  // two spare bits hold the carry until the next word folds it back in
  logic [17:0] acc;
  logic [7:0]  hi_byte;
  logic        lo_phase;
  logic [16:0] fold;

  assign fold    = {1'b0, acc[15:0]} + {15'b0, acc[17:16]};
  // second fold only matters when the first one wraps to 0x10000
  assign cks_sum = fold[15:0] + {15'b0, fold[16]};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      acc      <= '0;
      lo_phase <= 1'b0;
    end else if (in_val) begin
      if (in_sof) begin
        acc      <= '0;
        lo_phase <= 1'b1;
      end else if (lo_phase) begin
        acc      <= {2'b00, acc[15:0]} + {16'b0, acc[17:16]} + {2'b00, hi_byte, in_dat};
        lo_phase <= 1'b0;
      end else begin
        lo_phase <= 1'b1;
      end
    end
  end

  // high byte of the word in progress
  always_ff @(posedge clk) begin
    if (in_val && (in_sof || !lo_phase)) begin
      hi_byte <= in_dat;
    end
  end

  a_carry_bound: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (in_val && lo_phase && !in_sof) |=> (acc[17:16] <= 2'd1)
  );

endmodule

//--- hw/ipv4_hdr_parse.sv
`timescale 1ns/1ps

module ipv4_hdr_parse (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        in_val,
  input  logic        in_sof,
  input  logic        in_eof,
  input  logic [7:0]  in_dat,
  output logic        hdr_done,
  output logic        frame_short,
  output logic [3:0]  version,
  output logic [3:0]  ihl,
  output logic [15:0] total_len,
  output logic [15:0] id,
  output logic [7:0]  proto,
  output logic [31:0] src_ip,
  output logic [31:0] dst_ip
);

  ipv4_rx_pkg::parse_state_t state;

  // index of the byte currently on in_dat, the sof byte is index 0
  logic [5:0] cnt;
  logic [5:0] cnt_nxt;
  logic [5:0] hdr_len;
  logic       hdr_last;

  assign hdr_len  = {ihl, 2'b00};
  assign cnt_nxt  = cnt + 6'd1;
  assign hdr_last = (cnt_nxt >= hdr_len);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state       <= ipv4_rx_pkg::parse_idle;
      cnt         <= '0;
      hdr_done    <= 1'b0;
      frame_short <= 1'b0;
    end else begin
      hdr_done    <= 1'b0;
      frame_short <= 1'b0;
      if (in_val) begin
        if (in_sof) begin
          // a new frame restarts the parser from any state
          cnt <= 6'd1;
          if (in_eof) begin
            frame_short <= 1'b1;
            state       <= ipv4_rx_pkg::parse_idle;
          end else begin
            state <= ipv4_rx_pkg::parse_header;
          end
        end else begin
          case (state)
            ipv4_rx_pkg::parse_header, ipv4_rx_pkg::parse_skip: begin
              cnt <= cnt_nxt;
              if (hdr_last) begin
                hdr_done <= 1'b1;
                state    <= in_eof ? ipv4_rx_pkg::parse_idle : ipv4_rx_pkg::parse_payload;
              end else if (in_eof) begin
                frame_short <= 1'b1;
                state       <= ipv4_rx_pkg::parse_idle;
              end else if (cnt_nxt == 6'(ipv4_rx_pkg::ipv4_min_hdr_len)) begin
                // fixed part done, options follow
                state <= ipv4_rx_pkg::parse_skip;
              end
            end
            ipv4_rx_pkg::parse_payload: begin
              if (in_eof) begin
                state <= ipv4_rx_pkg::parse_idle;
              end
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  // field capture, multi-byte fields arrive msb first
  always_ff @(posedge clk) begin
    if (in_val) begin
      if (in_sof) begin
        version <= in_dat[7:4];
        ihl     <= in_dat[3:0];
      end else if (state == ipv4_rx_pkg::parse_header) begin
        case (cnt)
          6'd2, 6'd3:                total_len <= {total_len[7:0], in_dat};
          6'd4, 6'd5:                id        <= {id[7:0], in_dat};
          6'd9:                      proto     <= in_dat;
          6'd12, 6'd13, 6'd14, 6'd15: src_ip   <= {src_ip[23:0], in_dat};
          6'd16, 6'd17, 6'd18, 6'd19: dst_ip   <= {dst_ip[23:0], in_dat};
          default: begin
          end
        endcase
      end
    end
  end

  // header end lands on byte ihl*4, counted from the sof byte
  a_done_at_hdr_len: assert property (
    @(posedge clk) disable iff (fsm_rst)
    hdr_done |-> ((cnt == hdr_len) || (ihl == 4'd0))
  );

endmodule

//--- hw/ipv4_rx_pkg.sv
package ipv4_rx_pkg;

  // smallest legal header, five 32-bit words
  localparam int ipv4_min_hdr_len = 20;

  localparam logic [3:0] ipv4_version = 4'd4;

  // limited broadcast 255.255.255.255
  localparam logic [31:0] ipv4_broadcast = 32'hffff_ffff;

  // a header with a correct checksum field folds to all ones
  localparam logic [15:0] cks_good = 16'hffff;

  // parser states
  // skip covers the option bytes between byte 20 and ihl*4
  typedef enum logic [1:0] {
    parse_idle,
    parse_header,
    parse_payload,
    parse_skip
  } parse_state_t;

  // drop reasons, listed in the order the gate ranks them
  typedef enum logic [2:0] {
    drop_none,
    drop_bad_version,
    drop_bad_ihl,
    drop_bad_cks,
    drop_not_for_us,
    drop_short_frame
  } drop_reason_t;

endpackage
